// ==== source/coco_mem_params.svh ====
// widths, rom slot numbers, region bounds, floppy latch and warm-start addresses
`ifndef COCO_MEM_PARAMS_SVH
`define COCO_MEM_PARAMS_SVH

`define ROM_ADDR_BITS    13 // 8 KB rom slot
`define CART_ADDR_BITS   14 // 16 KB cartridge
`define RAM_ADDR_BITS    15 // 32 KB cpu ram
`define IOCTL_ADDR_BITS  17

// slot number comes from download address bits 16:13
`define ROM_SLOT_COUNT   10
`define SLOT_ROMA_TANDY  0
`define SLOT_ROM8_TANDY  1
`define SLOT_DISK_TANDY  2
`define SLOT_ROM8_DRAGON 3
`define SLOT_ROMA_DRAGON 4
`define SLOT_ROM8_D64_1  5
`define SLOT_ROMA_D64_1  6
`define SLOT_ROM8_D64_2  7
`define SLOT_ROMA_D64_2  8
`define SLOT_DISK_DRAGON 9

`define CART_MIN_SIZE    256 // anything bigger counts as a cartridge
`define WARM_START_ADDR  'h71

`define ROM8_BASE        16'h8000
`define ROMA_BASE        16'hA000
`define ROMC_BASE        16'hC000
`define IO_PAGE          8'hFF
`define FDC_LATCH_COCO   16'hFF40
`define FDC_LATCH_DRAGON 16'hFF48

`endif

// ==== source/coco_mem_pkg.sv ====
// shared bus structs, region enum and floppy control byte layouts
`include "coco_mem_params.svh"

package coco_mem_pkg;

	// static machine configuration
	typedef struct packed {
		logic dragon;
		logic mem64kb;
		logic disk_cart_enabled;
	} machine_cfg_t;

	typedef struct packed {
		logic [15:0] addr;
		logic        rw;    // 1 = read
		logic [7:0]  wdata;
		logic        e;     // E phase strobe
	} cpu_bus_t;

	// rom / cartridge download port
	typedef struct packed {
		logic [`IOCTL_ADDR_BITS-1:0] addr;
		logic [7:0]                  data;
		logic                        wr;
		logic                        download;
		logic                        cart;
		logic                        rom;
	} ioctl_t;

	typedef enum logic [2:0] {
		region_ram,
		region_rom8,
		region_roma,
		region_romc,
		region_pia0,
		region_pia1,
		region_io,
		region_none
	} region_t;

	// one-hot peripheral selects
	typedef struct packed {
		logic pia0;
		logic pia1;
		logic acia;
		logic fdc;
	} periph_sel_t;

	// pia1 port b bit 2 and its ddr bit
	typedef struct packed {
		logic ddr_b2;
		logic port_b2;
	} rom_bank_t;

	typedef struct packed {
		logic       halt_en;   // bit 7
		logic       drive_ds3; // fourth drive select
		logic       dden;
		logic       precomp;
		logic       motor;
		logic [2:0] drive_sel;
	} coco_fdc_ctrl_t;

	typedef struct packed {
		logic [1:0] unused;
		logic       nmi_en;
		logic       precomp;
		logic       dden;
		logic       motor;
		logic [1:0] drive_num;
	} dragon_fdc_ctrl_t;

	// same byte, decoded per machine
	typedef union packed {
		coco_fdc_ctrl_t   coco;
		dragon_fdc_ctrl_t dragon;
	} fdc_ctrl_u;

	typedef struct packed {
		logic [3:0] drive_sel; // one-hot
		logic       motor;
		logic       dden;
		logic       precomp;
	} fdc_drive_t;

endpackage

// ==== source/dual_port_ram.sv ====
// two-port synchronous ram, registered read on port a, write-only port b
module dual_port_ram #(
	parameter int addr_bits = 13,
	parameter int data_bits = 8
) (
	input  logic                 clk,

	input  logic [addr_bits-1:0] addr_a,
	input  logic [data_bits-1:0] wdata_a,
	input  logic                 we_a,
	output logic [data_bits-1:0] rdata_a,

	input  logic [addr_bits-1:0] addr_b,
	input  logic [data_bits-1:0] wdata_b,
	input  logic                 we_b
);

	logic [data_bits-1:0] mem [2**addr_bits];

	always_ff @(posedge clk) begin
		if (we_a)
			mem[addr_a] <= wdata_a;
		// port b written last so it wins a same-address collision
		if (we_b)
			mem[addr_b] <= wdata_b;
	end

	// read-before-write on port a
	always_ff @(posedge clk) begin
		rdata_a <= mem[addr_a];
	end

endmodule

// ==== source/coco_addr_decode.sv ====
// map type 0 region decode and peripheral chip selects
`include "coco_mem_params.svh"

module coco_addr_decode (
	input  coco_mem_pkg::cpu_bus_t     bus,
	input  coco_mem_pkg::machine_cfg_t cfg,
	output coco_mem_pkg::region_t      region,
	output coco_mem_pkg::periph_sel_t  periph_sel
);

	logic dragon64;
	logic d64_acia; // dragon 64 puts the acia on address bit 2

	assign dragon64 = cfg.dragon & cfg.mem64kb;
	assign d64_acia = dragon64 & bus.addr[2];

	always_comb begin
		region = coco_mem_pkg::region_none;
		if (bus.addr < `ROM8_BASE)
			region = coco_mem_pkg::region_ram;
		else if (bus.addr < `ROMA_BASE)
			region = coco_mem_pkg::region_rom8;
		else if (bus.addr < `ROMC_BASE)
			region = coco_mem_pkg::region_roma;
		else if (bus.addr[15:8] != `IO_PAGE)
			region = coco_mem_pkg::region_romc;
		else begin
			// 32 byte windows in the ff page
			case (bus.addr[7:5])
				3'd0:    region = coco_mem_pkg::region_pia0;
				3'd1:    region = coco_mem_pkg::region_pia1;
				3'd2:    region = coco_mem_pkg::region_io;
				default: region = coco_mem_pkg::region_none;
			endcase
		end
	end

	always_comb begin
		periph_sel.pia0 = (region == coco_mem_pkg::region_pia0) & ~d64_acia;
		periph_sel.acia = (region == coco_mem_pkg::region_pia0) & d64_acia;
		periph_sel.pia1 = (region == coco_mem_pkg::region_pia1);
		// coco fdc at ff48-ff4f, dragon at ff40-ff43
		if (cfg.dragon)
			periph_sel.fdc = (region == coco_mem_pkg::region_io) & (bus.addr[4:2] == 3'b000);
		else
			periph_sel.fdc = (region == coco_mem_pkg::region_io) & (bus.addr[4:3] == 2'b01);
	end

endmodule

// ==== source/rom_store.sv ====
// rom slots, cartridge store, cartridge-loaded flag and rom window read select
`include "coco_mem_params.svh"

module rom_store (
	input  logic                       clk,
	input  logic                       reset_n,
	input  coco_mem_pkg::cpu_bus_t     bus,
	input  coco_mem_pkg::machine_cfg_t cfg,
	input  coco_mem_pkg::ioctl_t       ioctl,
	input  logic                       cart_remove,
	input  coco_mem_pkg::rom_bank_t    bank,
	input  coco_mem_pkg::region_t      region,
	output logic [7:0]                 rom_rdata
);

	logic [7:0] slot_rdata [`ROM_SLOT_COUNT];
	logic [7:0] cart_rdata;
	logic       cart_loaded;
	logic       dragon64;
	logic       bank2;   // upper d64 bank, ddr set and port bit low
	logic       r_bank2;
	logic [7:0] rom8_byte;
	logic [7:0] roma_byte;
	logic [7:0] disk_byte;

	coco_mem_pkg::region_t r_region; // lines up with the ram read latency

	assign dragon64 = cfg.dragon & cfg.mem64kb;
	assign bank2    = bank.ddr_b2 & ~bank.port_b2;

	for (genvar i = 0; i < `ROM_SLOT_COUNT; i++) begin : g_slot
		dual_port_ram #(
			.addr_bits(`ROM_ADDR_BITS),
			.data_bits(8)
		) u_slot (
			.clk     (clk),
			.addr_a  (bus.addr[`ROM_ADDR_BITS-1:0]),
			.wdata_a (8'h00),
			.we_a    (1'b0),
			.rdata_a (slot_rdata[i]),
			.addr_b  (ioctl.addr[`ROM_ADDR_BITS-1:0]),
			.wdata_b (ioctl.data),
			.we_b    (ioctl.wr & ioctl.rom & (ioctl.addr[16:13] == 4'(i)))
		);
	end

	dual_port_ram #(
		.addr_bits(`CART_ADDR_BITS),
		.data_bits(8)
	) u_cart (
		.clk     (clk),
		.addr_a  (bus.addr[`CART_ADDR_BITS-1:0]),
		.wdata_a (8'h00),
		.we_a    (1'b0),
		.rdata_a (cart_rdata),
		.addr_b  (ioctl.addr[`CART_ADDR_BITS-1:0]),
		.wdata_b (ioctl.data),
		.we_b    (ioctl.wr & ioctl.cart)
	);

	// size check on the idle cycles of a cartridge download
	always_ff @(posedge clk) begin
		if (!reset_n)
			cart_loaded <= 1'b0;
		else if (ioctl.cart & ioctl.download & ~ioctl.wr)
			cart_loaded <= (ioctl.addr > `CART_MIN_SIZE);
		else if (cart_remove)
			cart_loaded <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			r_region <= coco_mem_pkg::region_none;
			r_bank2  <= 1'b0;
		end else begin
			r_region <= region;
			r_bank2  <= bank2;
		end
	end

	always_comb begin
		if (dragon64) begin
			rom8_byte = r_bank2 ? slot_rdata[`SLOT_ROM8_D64_2] : slot_rdata[`SLOT_ROM8_D64_1];
			roma_byte = r_bank2 ? slot_rdata[`SLOT_ROMA_D64_2] : slot_rdata[`SLOT_ROMA_D64_1];
		end else if (cfg.dragon) begin
			rom8_byte = slot_rdata[`SLOT_ROM8_DRAGON];
			roma_byte = slot_rdata[`SLOT_ROMA_DRAGON];
		end else begin
			rom8_byte = slot_rdata[`SLOT_ROM8_TANDY];
			roma_byte = slot_rdata[`SLOT_ROMA_TANDY];
		end
		disk_byte = cfg.dragon ? slot_rdata[`SLOT_DISK_DRAGON] : slot_rdata[`SLOT_DISK_TANDY];
	end

	always_comb begin
		case (r_region)
			coco_mem_pkg::region_rom8: rom_rdata = rom8_byte;
			coco_mem_pkg::region_roma: rom_rdata = roma_byte;
			coco_mem_pkg::region_romc: begin
				if (cart_loaded)
					rom_rdata = cart_rdata;
				else if (cfg.disk_cart_enabled)
					rom_rdata = disk_byte;
				else
					rom_rdata = 8'hFF; // empty slot
			end
			default: rom_rdata = 8'hFF;
		endcase
	end

endmodule

// ==== source/fdc_control.sv ====
// floppy control latch with coco and dragon layouts, nmi and halt generation
`include "coco_mem_params.svh"

module fdc_control (
	input  logic                       clk,
	input  logic                       reset_n,
	input  coco_mem_pkg::cpu_bus_t     bus,
	input  coco_mem_pkg::machine_cfg_t cfg,
	input  coco_mem_pkg::region_t      region,
	input  logic                       fdc_irq,
	input  logic                       fdc_drq,
	output coco_mem_pkg::fdc_drive_t   drive,
	output logic                       nmi,
	output logic                       halt
);

	coco_mem_pkg::fdc_ctrl_u  wr_ctrl;
	coco_mem_pkg::fdc_drive_t next_drive;
	logic                     next_nmi_en;
	logic                     next_halt_en;
	logic                     nmi_en;   // dragon only
	logic                     halt_en;  // coco only
	logic                     latch_we;

	assign wr_ctrl = bus.wdata;

	assign latch_we = bus.e & ~bus.rw & (region == coco_mem_pkg::region_io) &
		(bus.addr == (cfg.dragon ? `FDC_LATCH_DRAGON : `FDC_LATCH_COCO));

	always_comb begin
		if (cfg.dragon) begin
			next_drive.drive_sel = 4'b0001 << wr_ctrl.dragon.drive_num;
			next_drive.motor     = wr_ctrl.dragon.motor;
			next_drive.dden      = wr_ctrl.dragon.dden;
			next_drive.precomp   = wr_ctrl.dragon.precomp;
			next_nmi_en          = wr_ctrl.dragon.nmi_en;
			next_halt_en         = 1'b0;
		end else begin
			next_drive.drive_sel = {wr_ctrl.coco.drive_ds3, wr_ctrl.coco.drive_sel};
			next_drive.motor     = wr_ctrl.coco.motor;
			next_drive.dden      = wr_ctrl.coco.dden;
			next_drive.precomp   = wr_ctrl.coco.precomp;
			next_nmi_en          = 1'b0;
			next_halt_en         = wr_ctrl.coco.halt_en;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			drive   <= '0;
			nmi_en  <= 1'b0;
			halt_en <= 1'b0;
		end else begin
			if (latch_we) begin
				drive   <= next_drive;
				nmi_en  <= next_nmi_en;
				halt_en <= next_halt_en;
			end
			if (fdc_irq)
				halt_en <= 1'b0; // command done, release the cpu
		end
	end

	assign nmi  = fdc_irq & (cfg.dragon ? nmi_en : drive.dden);
	assign halt = ~cfg.dragon & halt_en & ~fdc_drq; // stall until data request

endmodule

// ==== source/coco_memory_map.sv ====
// memory map top: decode, rom store, cpu ram, floppy glue and read data mux
`include "coco_mem_params.svh"

module coco_memory_map (
	input  logic                       clk,
	input  logic                       reset_n,
	input  coco_mem_pkg::cpu_bus_t     bus,
	input  coco_mem_pkg::machine_cfg_t cfg,
	input  coco_mem_pkg::ioctl_t       ioctl,
	input  logic                       cart_remove,
	input  coco_mem_pkg::rom_bank_t    bank,
	input  logic                       hard_reset,
	input  logic [7:0]                 periph_rdata,
	input  logic [7:0]                 fdc_rdata,
	input  logic                       fdc_irq,
	input  logic                       fdc_drq,
	output logic [7:0]                 cpu_din,
	output coco_mem_pkg::periph_sel_t  periph_sel,
	output coco_mem_pkg::fdc_drive_t   drive,
	output logic                       nmi,
	output logic                       halt,
	output logic                       ledb
);

	coco_mem_pkg::region_t region;
	coco_mem_pkg::region_t r_region; // region of the read in flight
	logic [7:0]            ram_rdata;
	logic [7:0]            rom_rdata;
	logic [7:0]            periph_q;
	logic [7:0]            fdc_q;

	coco_addr_decode u_decode (
		.bus        (bus),
		.cfg        (cfg),
		.region     (region),
		.periph_sel (periph_sel)
	);

	rom_store u_rom (
		.clk         (clk),
		.reset_n     (reset_n),
		.bus         (bus),
		.cfg         (cfg),
		.ioctl       (ioctl),
		.cart_remove (cart_remove),
		.bank        (bank),
		.region      (region),
		.rom_rdata   (rom_rdata)
	);

	fdc_control u_fdc (
		.clk     (clk),
		.reset_n (reset_n),
		.bus     (bus),
		.cfg     (cfg),
		.region  (region),
		.fdc_irq (fdc_irq),
		.fdc_drq (fdc_drq),
		.drive   (drive),
		.nmi     (nmi),
		.halt    (halt)
	);

	// port b clears the warm-start flag so basic does a cold boot
	dual_port_ram #(
		.addr_bits(`RAM_ADDR_BITS),
		.data_bits(8)
	) u_ram (
		.clk     (clk),
		.addr_a  (bus.addr[`RAM_ADDR_BITS-1:0]),
		.wdata_a (bus.wdata),
		.we_a    (bus.e & ~bus.rw & (region == coco_mem_pkg::region_ram)),
		.rdata_a (ram_rdata),
		.addr_b  (`RAM_ADDR_BITS'(`WARM_START_ADDR)),
		.wdata_b (8'h00),
		.we_b    (hard_reset)
	);

	always_ff @(posedge clk) begin
		if (!reset_n)
			r_region <= coco_mem_pkg::region_none;
		else
			r_region <= region;
	end

	// external read data, same latency as the rams
	always_ff @(posedge clk) begin
		periph_q <= periph_rdata;
		fdc_q    <= fdc_rdata;
	end

	always_comb begin
		case (r_region)
			coco_mem_pkg::region_ram:  cpu_din = ram_rdata;
			coco_mem_pkg::region_rom8,
			coco_mem_pkg::region_roma,
			coco_mem_pkg::region_romc: cpu_din = rom_rdata;
			coco_mem_pkg::region_pia0,
			coco_mem_pkg::region_pia1: cpu_din = periph_q; // pia and acia share one input
			coco_mem_pkg::region_io:   cpu_din = fdc_q;
			default:                   cpu_din = 8'hFF;
		endcase
	end

	assign ledb = ~(ioctl.download | drive.motor); // active low activity led

endmodule

// ==== tb/coco_memory_map_assert.sv ====
// bound checker: reference model of ram, rom slots, cartridge and floppy latch with assertions
`include "coco_mem_params.svh"

module coco_memory_map_assert (
	input logic                       clk,
	input logic                       reset_n,
	input coco_mem_pkg::cpu_bus_t     bus,
	input coco_mem_pkg::machine_cfg_t cfg,
	input coco_mem_pkg::ioctl_t       ioctl,
	input logic                       cart_remove,
	input coco_mem_pkg::rom_bank_t    bank,
	input logic                       hard_reset,
	input logic [7:0]                 periph_rdata,
	input logic [7:0]                 fdc_rdata,
	input logic                       fdc_irq,
	input logic                       fdc_drq,
	input logic [7:0]                 cpu_din,
	input coco_mem_pkg::periph_sel_t  periph_sel,
	input coco_mem_pkg::fdc_drive_t   drive,
	input logic                       nmi,
	input logic                       halt,
	input logic                       ledb
);

	logic [7:0] ram_m  [2**`RAM_ADDR_BITS];
	logic [7:0] rom_m  [`ROM_SLOT_COUNT][2**`ROM_ADDR_BITS];
	logic [7:0] cart_m [2**`CART_ADDR_BITS];
	logic       cart_in;   // cartridge counted as loaded
	logic [7:0] ctrl_m;    // last floppy control byte
	logic       ctrl_set;
	logic       halt_en_m;
	logic [7:0] exp_din;
	logic       exp_valid;
	logic       pia0_win;
	logic       d64;

	coco_mem_pkg::periph_sel_t exp_sel;
	coco_mem_pkg::fdc_drive_t  exp_drive;

	int unsigned fail_count = 0;

	// byte the cpu should see one clock after presenting address a
	function automatic logic [7:0] expect_byte(input logic [15:0] a);
		int s8;
		int sa;
		int sd;
		if (!cfg.dragon) begin
			s8 = `SLOT_ROM8_TANDY;
			sa = `SLOT_ROMA_TANDY;
			sd = `SLOT_DISK_TANDY;
		end else if (!cfg.mem64kb) begin
			s8 = `SLOT_ROM8_DRAGON;
			sa = `SLOT_ROMA_DRAGON;
			sd = `SLOT_DISK_DRAGON;
		end else begin
			// bank 2 only with ddr set and port bit low
			s8 = (bank.ddr_b2 && !bank.port_b2) ? `SLOT_ROM8_D64_2 : `SLOT_ROM8_D64_1;
			sa = (bank.ddr_b2 && !bank.port_b2) ? `SLOT_ROMA_D64_2 : `SLOT_ROMA_D64_1;
			sd = `SLOT_DISK_DRAGON;
		end
		if (a < 16'h8000)
			return ram_m[a[14:0]];
		if (a < 16'hA000)
			return rom_m[s8][a[12:0]];
		if (a < 16'hC000)
			return rom_m[sa][a[12:0]];
		if (a < 16'hFF00) begin
			if (cart_in)
				return cart_m[a[13:0]];
			return cfg.disk_cart_enabled ? rom_m[sd][a[12:0]] : 8'hFF;
		end
		if (a < 16'hFF40)
			return periph_rdata; // pia0 and pia1
		if (a < 16'hFF60)
			return fdc_rdata;
		return 8'hFF;
	endfunction

	always @(posedge clk) begin
		exp_din   <= expect_byte(bus.addr);
		exp_valid <= reset_n & bus.rw;
		if (bus.e && !bus.rw && bus.addr < 16'h8000)
			ram_m[bus.addr[14:0]] <= bus.wdata;
		if (hard_reset)
			ram_m[`WARM_START_ADDR] <= 8'h00;
		if (ioctl.wr && ioctl.rom && ioctl.addr[16:13] < `ROM_SLOT_COUNT)
			rom_m[ioctl.addr[16:13]][ioctl.addr[12:0]] <= ioctl.data;
		if (ioctl.wr && ioctl.cart)
			cart_m[ioctl.addr[13:0]] <= ioctl.data;
		if (!reset_n) begin
			cart_in   <= 1'b0;
			ctrl_m    <= 8'h00;
			ctrl_set  <= 1'b0;
			halt_en_m <= 1'b0;
		end else begin
			if (ioctl.cart && ioctl.download && !ioctl.wr)
				cart_in <= (ioctl.addr > `CART_MIN_SIZE);
			else if (cart_remove)
				cart_in <= 1'b0;
			if (bus.e && !bus.rw && bus.addr == (cfg.dragon ? 16'hFF48 : 16'hFF40)) begin
				ctrl_m    <= bus.wdata;
				ctrl_set  <= 1'b1;
				halt_en_m <= !cfg.dragon && bus.wdata[7];
			end
			if (fdc_irq)
				halt_en_m <= 1'b0;
		end
	end

	assign d64      = cfg.dragon & cfg.mem64kb;
	assign pia0_win = (bus.addr[15:5] == 11'h7F8);

	always_comb begin
		exp_sel.pia0 = pia0_win & ~(d64 & bus.addr[2]);
		exp_sel.acia = pia0_win & d64 & bus.addr[2];
		exp_sel.pia1 = (bus.addr[15:5] == 11'h7F9);
		exp_sel.fdc  = cfg.dragon ? (bus.addr[15:2] == 14'h3FD0) : (bus.addr[15:3] == 13'h1FE9);
		exp_drive    = '0;
		if (ctrl_set && cfg.dragon) begin
			exp_drive.drive_sel = 4'b0001 << ctrl_m[1:0];
			exp_drive.motor     = ctrl_m[2];
			exp_drive.dden      = ctrl_m[3];
			exp_drive.precomp   = ctrl_m[4];
		end else if (ctrl_set) begin
			exp_drive.drive_sel = {ctrl_m[6], ctrl_m[2:0]};
			exp_drive.motor     = ctrl_m[3];
			exp_drive.precomp   = ctrl_m[4];
			exp_drive.dden      = ctrl_m[5];
		end
	end

	a_read_data: assert property (@(posedge clk) disable iff (!reset_n)
		exp_valid |-> cpu_din === exp_din)
	else begin
		fail_count++;
		$error("Fail cpu_din expected %h got %h", $sampled(exp_din), $sampled(cpu_din));
	end

	a_periph_sel: assert property (@(posedge clk) disable iff (!reset_n) periph_sel == exp_sel)
	else begin
		fail_count++;
		$error("Fail periph_sel expected %h got %h", $sampled(exp_sel), $sampled(periph_sel));
	end

	a_drive: assert property (@(posedge clk) disable iff (!reset_n) drive == exp_drive)
	else begin
		fail_count++;
		$error("Fail drive expected %h got %h", $sampled(exp_drive), $sampled(drive));
	end

	// coco dden and dragon nmi enable both sit in bit 5
	a_nmi: assert property (@(posedge clk) disable iff (!reset_n) nmi == (fdc_irq & ctrl_m[5]))
	else begin
		fail_count++;
		$error("Fail nmi expected %h got %h", $sampled(fdc_irq & ctrl_m[5]), $sampled(nmi));
	end

	a_halt: assert property (@(posedge clk) disable iff (!reset_n)
		halt == (!cfg.dragon & halt_en_m & !fdc_drq))
	else begin
		fail_count++;
		$error("Fail halt expected %h got %h",
			$sampled(!cfg.dragon & halt_en_m & !fdc_drq), $sampled(halt));
	end

	a_ledb: assert property (@(posedge clk) disable iff (!reset_n)
		ledb == !(ioctl.download | exp_drive.motor))
	else begin
		fail_count++;
		$error("Fail ledb expected %h got %h",
			$sampled(!(ioctl.download | exp_drive.motor)), $sampled(ledb));
	end

endmodule

bind coco_memory_map coco_memory_map_assert u_check (.*);

// ==== tb/coco_memory_map_tb.sv ====
// testbench for the memory map: clock, reset, stimulus, timeout and closing report
`include "coco_mem_params.svh"

module coco_memory_map_tb;

	localparam int max_cycles = 6000; // sequence needs well under 1000 cycles
	localparam int n_offs     = 8;

	logic                       clk;
	logic                       reset_n;
	coco_mem_pkg::cpu_bus_t     bus;
	coco_mem_pkg::machine_cfg_t cfg;
	coco_mem_pkg::ioctl_t       ioctl;
	logic                       cart_remove;
	coco_mem_pkg::rom_bank_t    bank;
	logic                       hard_reset;
	logic [7:0]                 periph_rdata;
	logic [7:0]                 fdc_rdata;
	logic                       fdc_irq;
	logic                       fdc_drq;
	logic [7:0]                 cpu_din;
	coco_mem_pkg::periph_sel_t  periph_sel;
	coco_mem_pkg::fdc_drive_t   drive;
	logic                       nmi;
	logic                       halt;
	logic                       ledb;

	int          seed;
	int          cycle_count = 0;
	logic [12:0] offs [n_offs];      // same offsets used in every rom slot
	logic [14:0] ram_addrs [n_offs];

	coco_memory_map dut (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == max_cycles) begin
			$display("timeout: stimulus did not finish within %0d cycles", max_cycles);
			$display("assertion failures: %0d", dut.u_check.fail_count);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// every input change lands 2 units after the edge
	task automatic tick();
		@(posedge clk);
		#2;
		periph_rdata = 8'($random(seed));
		fdc_rdata    = 8'($random(seed));
	endtask

	task automatic idle_bus();
		bus.addr  = 16'hFFFF;
		bus.rw    = 1'b1;
		bus.wdata = 8'h00;
		bus.e     = 1'b0;
	endtask

	task automatic read_at(input logic [15:0] a);
		bus.addr = a;
		bus.rw   = 1'b1;
		bus.e    = 1'b1;
		tick();
		idle_bus();
	endtask

	task automatic write_at(input logic [15:0] a, input logic [7:0] d);
		bus.addr  = a;
		bus.rw    = 1'b0;
		bus.wdata = d;
		bus.e     = 1'b1;
		tick();
		idle_bus();
	endtask

	task automatic load_byte(input logic [16:0] a, input logic [7:0] d, input logic to_cart);
		ioctl.addr     = a;
		ioctl.data     = d;
		ioctl.wr       = 1'b1;
		ioctl.download = 1'b1;
		ioctl.cart     = to_cart;
		ioctl.rom      = ~to_cart;
		tick();
		ioctl.wr = 1'b0;
	endtask

	task automatic end_download();
		tick(); // idle cycle, cartridge size is checked here
		ioctl = '0;
	endtask

	task automatic restart(input coco_mem_pkg::machine_cfg_t new_cfg);
		tick(); // last read still gets compared
		reset_n = 1'b0;
		cfg     = new_cfg;
		repeat (3) tick();
		reset_n = 1'b1;
	endtask

	task automatic read_rom_windows();
		for (int k = 0; k < n_offs; k++) begin
			read_at(16'h8000 | {3'b000, offs[k]});
			read_at(16'hA000 | {3'b000, offs[k]});
		end
	endtask

	initial begin
		seed         = 32'h28df4821;
		reset_n      = 1'b0;
		cfg          = '{dragon: 1'b0, mem64kb: 1'b0, disk_cart_enabled: 1'b1};
		ioctl        = '0;
		bank         = '0;
		cart_remove  = 1'b0;
		hard_reset   = 1'b0;
		periph_rdata = 8'h00;
		fdc_rdata    = 8'h00;
		fdc_irq      = 1'b0;
		fdc_drq      = 1'b0;
		idle_bus();
		for (int k = 0; k < n_offs; k++) begin
			offs[k]      = 13'($random(seed));
			ram_addrs[k] = 15'($random(seed));
		end
		ram_addrs[0] = 15'h0071; // warm-start byte
		restart(cfg);

		// rom slots, then coco and dragon 32 windows
		for (int s = 0; s < `ROM_SLOT_COUNT; s++)
			for (int k = 0; k < n_offs; k++)
				load_byte({4'(s), offs[k]}, 8'($random(seed)), 1'b0);
		end_download();
		read_rom_windows();
		restart('{dragon: 1'b1, mem64kb: 1'b0, disk_cart_enabled: 1'b1});
		read_rom_windows();

		// dragon 64 banks and the pia0 / acia split
		restart('{dragon: 1'b1, mem64kb: 1'b1, disk_cart_enabled: 1'b1});
		for (int b = 0; b < 4; b++) begin
			bank = 2'(b);
			read_rom_windows();
		end
		for (int a = 16'hFF00; a < 16'hFF08; a++)
			read_at(16'(a));

		// ram, warm-start clear, unmapped and peripheral reads
		for (int k = 0; k < n_offs; k++)
			write_at({1'b0, ram_addrs[k]}, 8'($random(seed)));
		for (int k = 0; k < n_offs; k++)
			read_at({1'b0, ram_addrs[k]});
		hard_reset = 1'b1;
		tick();
		hard_reset = 1'b0;
		read_at(16'h0071);
		read_at(16'hFF10);
		read_at(16'hFF30);
		read_at(16'hFF44);
		read_at(16'hFF60);
		read_at(16'hFF80);
		read_at(16'hFFFF);

		// cartridge, then fall back to disk rom and to empty
		restart('{dragon: 1'b0, mem64kb: 1'b0, disk_cart_enabled: 1'b1});
		for (int a = 0; a < 300; a++)
			load_byte(17'(a), 8'($random(seed)), 1'b1);
		end_download();
		for (int k = 0; k < 16; k++)
			read_at(16'hC000 + 16'(k * 19));
		cart_remove = 1'b1;
		tick();
		cart_remove = 1'b0;
		for (int k = 0; k < n_offs; k++)
			read_at(16'hC000 | {3'b000, offs[k]});
		restart('{dragon: 1'b0, mem64kb: 1'b0, disk_cart_enabled: 1'b0});
		for (int k = 0; k < n_offs; k++)
			read_at(16'hC000 | {3'b000, offs[k]});

		// coco floppy latch: halt enable, dden, motor, drive 0
		write_at(16'hFF40, 8'hA9);
		fdc_drq = 1'b1;
		tick();
		fdc_drq = 1'b0;
		repeat (2) tick();
		fdc_irq = 1'b1;
		tick();
		fdc_irq = 1'b0;
		repeat (2) tick();
		write_at(16'hFF40, 8'h56); // fourth select bit and precomp, motor off
		for (int a = 16'hFF40; a < 16'hFF50; a++)
			read_at(16'(a));

		// dragon latch with nmi enable on each drive number and varied dden and precomp
		restart('{dragon: 1'b1, mem64kb: 1'b0, disk_cart_enabled: 1'b1});
		for (int d = 0; d < 4; d++) begin
			write_at(16'hFF48, 8'h24 | 8'(d) | 8'(d << 3));
			fdc_irq = 1'b1;
			tick();
			fdc_irq = 1'b0;
			tick();
		end
		for (int a = 16'hFF40; a < 16'hFF50; a++)
			read_at(16'(a));
		write_at(16'hFF48, 8'h00); // motor off
		repeat (3) tick();

		$display("assertion failures: %0d", dut.u_check.fail_count);
		if (dut.u_check.fail_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== coco_memory_map.f ====
+incdir+source
source/coco_mem_pkg.sv
source/dual_port_ram.sv
source/coco_addr_decode.sv
source/rom_store.sv
source/fdc_control.sv
source/coco_memory_map.sv
tb/coco_memory_map_assert.sv
tb/coco_memory_map_tb.sv

// ==== Bender.yml ====
package:
  name: coco_memory_map

sources:
  - include_dirs:
      - source
    files:
      - source/coco_mem_pkg.sv
      - source/dual_port_ram.sv
      - source/coco_addr_decode.sv
      - source/rom_store.sv
      - source/fdc_control.sv
      - source/coco_memory_map.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/coco_memory_map_assert.sv
      - tb/coco_memory_map_tb.sv
